// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dcache_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               dmemren,
   input  logic               dmemwen,
   input  dcache_pkg::word_t  dmemaddr,
   input  dcache_pkg::word_t  dmemstore,
   input  logic               halt,
   input  logic               hit,
   input  logic               hit_way,
   input  logic               lru_way_out,
   input  dcache_pkg::tag_t   way0_tag,
   input  dcache_pkg::tag_t   way1_tag,
   input  logic               way0_valid,
   input  logic               way1_valid,
   input  logic               way0_dirty,
   input  logic               way1_dirty,
   input  dcache_pkg::word_t  way0_word0,
   input  dcache_pkg::word_t  way0_word1,
   input  dcache_pkg::word_t  way1_word0,
   input  dcache_pkg::word_t  way1_word1,
   input  dcache_pkg::word_t  dload,
   input  logic               dwait,
   output logic               dhit,
   output logic               flushed,
   output logic               dren,
   output logic               dwen,
   output dcache_pkg::word_t  daddr,
   output dcache_pkg::word_t  dstore,
   output dcache_pkg::index_t set_index,
   output logic               wr_en,
   output logic               wr_way,
   output logic               wr_word,
   output dcache_pkg::word_t  wr_data,
   output logic               fill_tag_en,
   output dcache_pkg::tag_t   fill_tag,
   output logic               set_valid,
   output logic               set_dirty,
   output logic               clr_dirty,
   output logic               lru_en,
   output logic               lru_way
);
   import dcache_pkg::*;

   cache_state_t state;
   cache_state_t next_state;

   // flush walk position, msb picks the way, low bits the set
   logic [$clog2(num_ways)+index_width-1:0] flush_row;

   logic  victim_way;
   logic  req;
   logic  in_flush;
   logic  mem_word;
   // block used by write-back, fill and flush
   logic  tgt_way;
   tag_t  tgt_tag;
   logic  tgt_busy;
   word_t tgt_word0;
   word_t tgt_word1;

   assign req      = dmemren || dmemwen;
   assign in_flush = state inside {flush_scan, flush_word0, flush_word1, halted};
   assign mem_word = state inside {wb_word1, fill_word1, flush_word1};

   assign set_index = in_flush ? flush_row[index_width-1:0] : dmemaddr[5:3];

   // in idle the candidate victim is the way not used last
   always_comb
   begin
      if (in_flush)
         tgt_way = flush_row[index_width];
      else if (state == idle)
         tgt_way = !lru_way_out;
      else
         tgt_way = victim_way;
   end

   assign tgt_tag   = tgt_way ? way1_tag : way0_tag;
   assign tgt_word0 = tgt_way ? way1_word0 : way0_word0;
   assign tgt_word1 = tgt_way ? way1_word1 : way0_word1;
   // valid and dirty, so it must go back to memory
   assign tgt_busy  = tgt_way ? (way1_valid && way1_dirty) : (way0_valid && way0_dirty);

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state      <= idle;
         flush_row  <= '0;
         victim_way <= 1'b0;
      end
      else
      begin
         state <= next_state;
         // lru cannot change during a miss, so the choice made in idle holds
         if (state == idle)
            victim_way <= tgt_way;
         if (state == flush_scan && !tgt_busy && !(&flush_row))
            flush_row <= flush_row + 1'b1;
      end
   end

   always_comb
   begin
      next_state = state;
      case (state)
         idle:
         begin
            if (halt)
               next_state = flush_scan;
            else if (req && !hit)
               next_state = tgt_busy ? wb_word0 : fill_word0;
         end
         wb_word0:    if (!dwait) next_state = wb_word1;
         wb_word1:    if (!dwait) next_state = fill_word0;
         fill_word0:  if (!dwait) next_state = fill_word1;
         fill_word1:  if (!dwait) next_state = idle;
         flush_scan:
         begin
            // a written-back block is rescanned once, then found clean
            if (tgt_busy)
               next_state = flush_word0;
            else if (&flush_row)
               next_state = halted;
         end
         flush_word0: if (!dwait) next_state = flush_word1;
         flush_word1: if (!dwait) next_state = flush_scan;
         halted:      next_state = halted;
         default:     next_state = idle;
      endcase
   end

   // processor side
   assign dhit    = (state == idle) && req && hit;
   assign flushed = (state == halted);

   // memory side
   assign dren = state inside {fill_word0, fill_word1};
   assign dwen = state inside {wb_word0, wb_word1, flush_word0, flush_word1};

   always_comb
   begin
      daddr  = '0;
      dstore = '0;
      if (dren)
         daddr = {dmemaddr[31:3], mem_word, 2'b00};
      else if (dwen)
      begin
         // victim address rebuilt from stored tag and set
         daddr  = {tgt_tag, set_index, mem_word, 2'b00};
         dstore = mem_word ? tgt_word1 : tgt_word0;
      end
   end

   // store commands
   assign fill_tag = dmemaddr[31:6];
   assign lru_en   = dhit;
   assign lru_way  = hit_way;

   always_comb
   begin
      wr_en       = 1'b0;
      wr_way      = tgt_way;
      wr_word     = mem_word;
      wr_data     = dload;
      fill_tag_en = 1'b0;
      set_valid   = 1'b0;
      set_dirty   = 1'b0;
      clr_dirty   = 1'b0;
      case (state)
         idle:
         begin
            // write hit
            wr_way    = hit_way;
            wr_word   = dmemaddr[2];
            wr_data   = dmemstore;
            wr_en     = dhit && dmemwen;
            set_dirty = dhit && dmemwen;
         end
         fill_word0:
            wr_en = !dwait;
         fill_word1:
         begin
            wr_en       = !dwait;
            fill_tag_en = !dwait;
            set_valid   = !dwait;
            set_dirty   = !dwait && dmemwen;
         end
         // second word accepted, block is clean
         wb_word1, flush_word1:
            clr_dirty = !dwait;
         default:
            wr_en = 1'b0;
      endcase
   end

   assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
      else $error("dcache_ctrl: dren and dwen both high");

   // request held steady while memory stalls
   assert property (@(posedge CLK) disable iff (!nRST)
      (dren || dwen) && dwait |=> $stable(daddr) && $stable(dstore))
      else $error("dcache_ctrl: memory request changed under dwait");

endmodule

// File: hdl/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
   input  dcache_pkg::tag_t  req_tag,
   input  logic              word_sel,
   input  dcache_pkg::tag_t  way0_tag,
   input  dcache_pkg::tag_t  way1_tag,
   input  logic              way0_valid,
   input  logic              way1_valid,
   input  dcache_pkg::word_t way0_word0,
   input  dcache_pkg::word_t way0_word1,
   input  dcache_pkg::word_t way1_word0,
   input  dcache_pkg::word_t way1_word1,
   output logic              hit,
   output logic              hit_way,
   output dcache_pkg::word_t load_word
);
   import dcache_pkg::*;

   logic  way0_match;
   logic  way1_match;
   word_t way0_sel;
   word_t way1_sel;

   // tag compare, only valid blocks count
   assign way0_match = way0_valid && (way0_tag == req_tag);
   assign way1_match = way1_valid && (way1_tag == req_tag);

   assign hit     = way0_match || way1_match;
   // way1 reported only when it matches
   assign hit_way = way1_match;

   // word within the block
   assign way0_sel = word_sel ? way0_word1 : way0_word0;
   assign way1_sel = word_sel ? way1_word1 : way1_word0;

   assign load_word = hit_way ? way1_sel : way0_sel;

   // a block is never filled into a set that already holds its tag
   always_comb
   begin
      if (way0_valid && way1_valid)
      begin
         assert (way0_tag != way1_tag)
            else $error("dcache_lookup: both ways hold the same tag");
      end
   end

endmodule

// File: hdl/dcache_pkg.sv
package dcache_pkg;

   // geometry of the cache
   localparam int word_width  = 32;
   localparam int num_sets    = 8;
   localparam int index_width = 3;
   localparam int num_ways    = 2;

   // address bits above set index and block offset
   localparam int tag_width   = 26;

   // address layout
   // [31:6] tag, [5:3] set index, [2] word in block, [1:0] byte, ignored

   typedef logic [word_width-1:0]  word_t;
   typedef logic [tag_width-1:0]   tag_t;
   typedef logic [index_width-1:0] index_t;

   // controller states
   // nine states, so the encoding needs four bits
   typedef enum logic [3:0] {
      idle,
      wb_word0,
      wb_word1,
      fill_word0,
      fill_word1,
      flush_scan,
      flush_word0,
      flush_word1,
      halted
   } cache_state_t;

endpackage

// File: hdl/dcache_store.sv
`timescale 1ns/1ps

module dcache_store (
   input  logic               CLK,
   input  logic               nRST,
   input  dcache_pkg::index_t set_index,
   input  logic               wr_en,
   input  logic               wr_way,
   input  logic               wr_word,
   input  dcache_pkg::word_t  wr_data,
   input  logic               fill_tag_en,
   input  dcache_pkg::tag_t   fill_tag,
   input  logic               set_valid,
   input  logic               set_dirty,
   input  logic               clr_dirty,
   input  logic               lru_en,
   input  logic               lru_way,
   output dcache_pkg::tag_t   way0_tag,
   output dcache_pkg::tag_t   way1_tag,
   output logic               way0_valid,
   output logic               way1_valid,
   output logic               way0_dirty,
   output logic               way1_dirty,
   output dcache_pkg::word_t  way0_word0,
   output dcache_pkg::word_t  way0_word1,
   output dcache_pkg::word_t  way1_word0,
   output dcache_pkg::word_t  way1_word1,
   output logic               lru_way_out
);
   import dcache_pkg::*;

   // tag and data arrays, first index is the way
   tag_t  tag_mem   [num_ways][num_sets];
   word_t word0_mem [num_ways][num_sets];
   word_t word1_mem [num_ways][num_sets];

   // status bits, one per block
   logic [num_sets-1:0] valid_bits [num_ways];
   logic [num_sets-1:0] dirty_bits [num_ways];

   // most recently used way of each set
   logic [num_sets-1:0] mru_bits;

   // block status, cleared on reset
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int w = 0; w < num_ways; w++)
         begin
            valid_bits[w] <= '0;
            dirty_bits[w] <= '0;
         end
         mru_bits <= '0;
      end
      else
      begin
         if (set_valid)
            valid_bits[wr_way][set_index] <= 1'b1;
         // a fill for a pending write marks the block dirty right away
         if (set_dirty)
            dirty_bits[wr_way][set_index] <= 1'b1;
         else if (clr_dirty)
            dirty_bits[wr_way][set_index] <= 1'b0;
         if (lru_en)
            mru_bits[set_index] <= lru_way;
      end
   end

   // tags and words
   always_ff @(posedge CLK)
   begin
      if (fill_tag_en)
         tag_mem[wr_way][set_index] <= fill_tag;
      if (wr_en && !wr_word)
         word0_mem[wr_way][set_index] <= wr_data;
      if (wr_en && wr_word)
         word1_mem[wr_way][set_index] <= wr_data;
   end

   // addressed set, read combinationally
   assign way0_tag    = tag_mem[0][set_index];
   assign way1_tag    = tag_mem[1][set_index];
   assign way0_valid  = valid_bits[0][set_index];
   assign way1_valid  = valid_bits[1][set_index];
   assign way0_dirty  = dirty_bits[0][set_index];
   assign way1_dirty  = dirty_bits[1][set_index];
   assign way0_word0  = word0_mem[0][set_index];
   assign way0_word1  = word1_mem[0][set_index];
   assign way1_word0  = word0_mem[1][set_index];
   assign way1_word1  = word1_mem[1][set_index];
   assign lru_way_out = mru_bits[set_index];

   // the controller must not set and clear dirty in one cycle
   assert property (@(posedge CLK) disable iff (!nRST) !(set_dirty && clr_dirty))
      else $error("dcache_store: set_dirty and clr_dirty both high");

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmemren,
   input  logic              dmemwen,
   input  dcache_pkg::word_t dmemaddr,
   input  dcache_pkg::word_t dmemstore,
   input  logic              halt,
   input  dcache_pkg::word_t dload,
   input  logic              dwait,
   output logic              dhit,
   output dcache_pkg::word_t dmemload,
   output logic              flushed,
   output logic              dren,
   output logic              dwen,
   output dcache_pkg::word_t daddr,
   output dcache_pkg::word_t dstore
);
   import dcache_pkg::*;

   // store to lookup and controller
   tag_t   way0_tag, way1_tag;
   logic   way0_valid, way1_valid;
   logic   way0_dirty, way1_dirty;
   word_t  way0_word0, way0_word1, way1_word0, way1_word1;
   logic   lru_way_out;

   // lookup to controller
   logic   hit, hit_way;

   // controller to store
   index_t set_index;
   logic   wr_en, wr_way, wr_word;
   word_t  wr_data;
   logic   fill_tag_en;
   tag_t   fill_tag;
   logic   set_valid, set_dirty, clr_dirty;
   logic   lru_en, lru_way;

   dcache_store dcache_store_i (
      .CLK, .nRST, .set_index, .wr_en, .wr_way, .wr_word, .wr_data,
      .fill_tag_en, .fill_tag, .set_valid, .set_dirty, .clr_dirty, .lru_en, .lru_way,
      .way0_tag, .way1_tag, .way0_valid, .way1_valid, .way0_dirty, .way1_dirty,
      .way0_word0, .way0_word1, .way1_word0, .way1_word1, .lru_way_out
   );

   dcache_lookup dcache_lookup_i (
      .req_tag (dmemaddr[31:6]),
      .word_sel (dmemaddr[2]),
      .way0_tag, .way1_tag, .way0_valid, .way1_valid,
      .way0_word0, .way0_word1, .way1_word0, .way1_word1,
      .hit, .hit_way,
      .load_word (dmemload)
   );

   dcache_ctrl dcache_ctrl_i (
      .CLK, .nRST, .dmemren, .dmemwen, .dmemaddr, .dmemstore, .halt,
      .hit, .hit_way, .lru_way_out,
      .way0_tag, .way1_tag, .way0_valid, .way1_valid, .way0_dirty, .way1_dirty,
      .way0_word0, .way0_word1, .way1_word0, .way1_word1,
      .dload, .dwait, .dhit, .flushed, .dren, .dwen, .daddr, .dstore,
      .set_index, .wr_en, .wr_way, .wr_word, .wr_data, .fill_tag_en, .fill_tag,
      .set_valid, .set_dirty, .clr_dirty, .lru_en, .lru_way
   );

   // the flush walk leaves no valid block dirty in either way
   assert property (@(posedge CLK) disable iff (!nRST)
      dcache_ctrl_i.state == halted
      |-> ((dcache_store_i.valid_bits[0] & dcache_store_i.dirty_bits[0]) == '0)
          && ((dcache_store_i.valid_bits[1] & dcache_store_i.dirty_bits[1]) == '0))
      else $error("dcache_top: dirty block left after flush");

endmodule

// File: src.f
hdl/dcache_pkg.sv
hdl/dcache_store.sv
hdl/dcache_lookup.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/tb_ram.sv
verif/dcache_tb.sv

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
   import dcache_pkg::*;

   // read pairs, write-read triples, eviction, lru and random mix
   localparam int num_ops     = 16 + 24 + 8 + 4 + 300;
   // a dirty miss is four memory words of at most four cycles each
   localparam int cycle_limit = 40 * num_ops + 800;

   logic       CLK;
   logic       nRST;
   logic       dmemren;
   logic       dmemwen;
   logic       halt;
   word_t      dmemaddr;
   word_t      dmemstore;
   logic       dhit;
   logic       flushed;
   word_t      dmemload;
   logic       dren;
   logic       dwen;
   logic       dwait;
   word_t      daddr;
   word_t      dstore;
   word_t      dload;
   logic [1:0] stall_cycles;

   logic [31:0] lfsr = 32'h168f_2372;
   // expected contents of every memory word
   word_t       model [64];
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;
   // write-back bursts seen on the memory side
   int          wb_count = 0;
   word_t       last_wb_addr = '0;

   dcache_top dcache_top_i (
      .CLK, .nRST, .dmemren, .dmemwen, .dmemaddr, .dmemstore, .halt,
      .dload, .dwait, .dhit, .dmemload, .flushed, .dren, .dwen, .daddr, .dstore
   );

   tb_ram tb_ram_i (
      .CLK, .nRST, .dren, .dwen, .daddr, .dstore, .stall_cycles, .dload, .dwait
   );

   initial
   begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   always @(posedge CLK)
   begin
      if (cycles >= cycle_limit)
      begin
         $display("timeout after %0d cycles, the cache stopped answering", cycles);
         $display("Simulation failed");
         $finish;
      end
      else
         cycles <= cycles + 1;
   end

   // word0 of each burst marks the victim block address
   always @(negedge CLK)
   begin
      if (dwen && !dwait && !daddr[2])
      begin
         wb_count     <= wb_count + 1;
         last_wb_addr <= daddr;
      end
   end

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++)
      begin
         fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr  = {lfsr[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   // tag in [31:6], set in [5:3], word in [2]
   function automatic word_t make_addr(input logic [1:0] tag, input logic [2:0] set,
                                       input logic word);
      return {24'h0, tag, set, word, 2'b00};
   endfunction

   function automatic word_t random_addr();
      logic [1:0] tag;
      logic [2:0] set;
      logic       word;
      tag  = 2'(random_bits(2));
      set  = 3'(random_bits(3));
      word = 1'(random_bits(1));
      return make_addr(tag, set, word);
   endfunction

   // one processor access, held until dhit, reads checked against the model
   task automatic access(input logic is_write, input word_t addr, input word_t data);
      @(posedge CLK);
      stall_cycles <= 2'(random_bits(2));
      dmemren      <= !is_write;
      dmemwen      <= is_write;
      dmemaddr     <= addr;
      dmemstore    <= data;
      @(negedge CLK);
      while (!dhit)
         @(negedge CLK);
      if (is_write)
         model[addr[7:2]] = data;
      else
      begin
         checks++;
         if (dmemload !== model[addr[7:2]])
         begin
            $display("Mismatch dmemload at %h: got %h, expected %h",
                     addr, dmemload, model[addr[7:2]]);
            errors++;
         end
      end
      // access completes on this edge
      @(posedge CLK);
      dmemren <= 1'b0;
      dmemwen <= 1'b0;
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%s: %0d errors", name, errors - errors_before);
   endtask

   initial
   begin
      word_t      a;
      word_t      b;
      word_t      c;
      word_t      data;
      logic       is_write;
      logic [2:0] set;
      int         errors_before;
      int         wb_before;
      nRST         = 1'b0;
      dmemren      = 1'b0;
      dmemwen      = 1'b0;
      halt         = 1'b0;
      dmemaddr     = '0;
      dmemstore    = '0;
      stall_cycles = '0;
      repeat (5) @(posedge CLK);
      nRST <= 1'b1;
      // model starts from the ram's reset contents
      for (int i = 0; i < 64; i++)
         model[i] = tb_ram_i.mem[i];

      // refill after reset, then a hit on the same word
      errors_before = errors;
      for (int i = 0; i < 8; i++)
      begin
         a = random_addr();
         access(1'b0, a, '0);
         access(1'b0, a, '0);
      end
      report_test("read after reset", errors_before);

      errors_before = errors;
      for (int i = 0; i < 8; i++)
      begin
         a    = random_addr();
         // flip a tag bit, same set
         b    = a ^ 32'h40;
         data = random_bits(32);
         access(1'b1, a, data);
         access(1'b0, b, '0);
         access(1'b0, a, '0);
      end
      report_test("write then read", errors_before);

      // third tag in a set pushes out the dirty block written first
      errors_before = errors;
      for (int i = 0; i < 2; i++)
      begin
         set  = 3'(random_bits(3));
         a    = make_addr(2'd0, set, 1'b1);
         b    = make_addr(2'd1, set, 1'b0);
         c    = make_addr(2'd2, set, 1'b0);
         data = random_bits(32);
         access(1'b1, a, data);
         access(1'b0, b, '0);
         access(1'b0, c, '0);
         checks++;
         if (tb_ram_i.mem[a[7:2]] !== data)
         begin
            $display("Mismatch tb_ram_i.mem at %h: got %h, expected %h",
                     a, tb_ram_i.mem[a[7:2]], data);
            errors++;
         end
         access(1'b0, a, '0);
      end
      report_test("eviction with write-back", errors_before);

      // touching A again leaves B as the victim for C
      errors_before = errors;
      set = 3'(random_bits(3));
      a   = make_addr(2'd1, set, 1'b0);
      b   = make_addr(2'd2, set, 1'b0);
      c   = make_addr(2'd3, set, 1'b0);
      access(1'b1, a, random_bits(32));
      access(1'b1, b, random_bits(32));
      access(1'b0, a, '0);
      wb_before = wb_count;
      access(1'b0, c, '0);
      checks++;
      if (wb_count != wb_before + 1)
      begin
         $display("LRU miss wrote back %0d blocks instead of one", wb_count - wb_before);
         errors++;
      end
      checks++;
      if (last_wb_addr !== b)
      begin
         $display("Mismatch daddr of write-back: got %h, expected %h", last_wb_addr, b);
         errors++;
      end
      report_test("lru victim choice", errors_before);

      errors_before = errors;
      for (int i = 0; i < 300; i++)
      begin
         is_write = 1'(random_bits(1));
         a        = random_addr();
         data     = random_bits(32);
         access(is_write, a, data);
      end
      report_test("random mix", errors_before);

      errors_before = errors;
      @(posedge CLK);
      halt <= 1'b1;
      @(negedge CLK);
      while (!flushed)
         @(negedge CLK);
      // flushed holds and memory stays quiet
      repeat (10)
      begin
         @(negedge CLK);
         checks++;
         if (!flushed || dren || dwen)
         begin
            $display("flushed dropped or memory was accessed after the flush");
            errors++;
         end
      end
      for (int i = 0; i < 64; i++)
      begin
         checks++;
         if (tb_ram_i.mem[i] !== model[i])
         begin
            $display("Mismatch tb_ram_i.mem[%0d]: got %h, expected %h",
                     i, tb_ram_i.mem[i], model[i]);
            errors++;
         end
      end
      report_test("halt flush", errors_before);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: verif/tb_ram.sv
`timescale 1ns/1ps

module tb_ram (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dren,
   input  logic              dwen,
   input  dcache_pkg::word_t daddr,
   input  dcache_pkg::word_t dstore,
   input  logic [1:0]        stall_cycles,
   output dcache_pkg::word_t dload,
   output logic              dwait
);
   import dcache_pkg::*;

   // 64 words cover four tags, eight sets and two words per block
   word_t      mem [64];
   logic [1:0] waited;

   // stall until the requested number of wait cycles has passed
   assign dwait = (dren || dwen) && (waited < stall_cycles);
   // read data comes straight from the array, valid when dwait drops
   assign dload = mem[daddr[7:2]];

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         waited <= '0;
         // fill pattern carries the whole word address in both halves
         for (int i = 0; i < 64; i++)
            mem[i] <= 32'hc0de_0000 ^ (32'(i) * 32'h0001_0004);
      end
      else if (dren || dwen)
      begin
         if (dwait)
            waited <= waited + 1'b1;
         else
         begin
            // word accepted, next request starts a fresh stall count
            waited <= '0;
            if (dwen)
               mem[daddr[7:2]] <= dstore;
         end
      end
   end

endmodule
